// File: logic/lc3_isa_pkg.sv
package lc3_isa_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_IDX_W = 3;
    localparam int NUM_REGS  = 1 << REG_IDX_W;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    // flags kept in n, z, p order to line up with the BR condition bits
    typedef logic [2:0]           nzp_t;

    localparam nzp_t NZP_RESET = 3'b010;

    // instruction fields
    localparam int OPC_MSB = 15;
    localparam int OPC_LSB = 12;
    localparam int DR_MSB  = 11;
    localparam int DR_LSB  = 9;
    localparam int SR1_MSB = 8;
    localparam int SR1_LSB = 6;
    localparam int IMM_BIT = 5;
    localparam int SR2_MSB = 2;
    localparam int SR2_LSB = 0;

    // immediate and offset widths taken from the low end of the word
    localparam int IMM5_W = 5;
    localparam int OFF6_W = 6;
    localparam int OFF9_W = 9;

    typedef enum logic [3:0] {
        OP_BR  = 4'b0000,
        OP_ADD = 4'b0001,
        OP_LD  = 4'b0010,
        OP_ST  = 4'b0011,
        OP_AND = 4'b0101,
        OP_NOT = 4'b1001,
        OP_JMP = 4'b1100,
        OP_LEA = 4'b1110
    } opcode_t;

endpackage

// File: logic/lc3_ctrl_pkg.sv
package lc3_ctrl_pkg;

    // microstates of the sequencer
    typedef enum logic [3:0] {
        S_FETCH_ADDR,
        S_FETCH_MEM,
        S_FETCH_IR,
        S_DECODE,
        S_ALU_OP,
        S_LEA,
        S_MEM_ADDR,
        S_LD_MEM,
        S_LD_REG,
        S_ST_DATA,
        S_ST_MEM,
        S_BR_TAKE,
        S_JMP
    } state_t;

    // who drives the shared bus
    typedef enum logic [2:0] {
        BUS_NONE,
        BUS_PC,
        BUS_ADDR,
        BUS_ALU,
        BUS_MDR
    } bus_src_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_AND,
        ALU_NOT,
        ALU_PASS_A
    } alu_op_t;

    // next PC source
    typedef enum logic [1:0] {
        PC_INCR,
        PC_ADDR,
        PC_BUS
    } pc_sel_t;

    // address adder inputs
    typedef enum logic {
        BASE_PC,
        BASE_REG
    } addr_base_t;

    typedef enum logic [1:0] {
        OFF_ZERO,
        OFF_6,
        OFF_9
    } addr_off_t;

endpackage

// File: logic/lc3_control.sv
module lc3_control (
    input  logic                      i_Clk,
    input  logic                      rst_n,
    input  lc3_isa_pkg::word_t        bus,
    input  lc3_isa_pkg::nzp_t         nzp,
    input  logic                      mem_done,
    output lc3_isa_pkg::word_t        ir,
    output lc3_ctrl_pkg::bus_src_t    bus_src,
    output lc3_ctrl_pkg::alu_op_t     alu_op,
    output lc3_ctrl_pkg::pc_sel_t     pc_sel,
    output lc3_ctrl_pkg::addr_base_t  addr_base,
    output lc3_ctrl_pkg::addr_off_t   addr_off,
    output lc3_isa_pkg::reg_idx_t     sr1,
    output lc3_isa_pkg::reg_idx_t     sr2,
    output lc3_isa_pkg::reg_idx_t     dr,
    output logic                      ld_reg,
    output logic                      ld_cc,
    output logic                      ld_pc,
    output logic                      ld_mar,
    output logic                      ld_mdr,
    output logic                      mem_start,
    output logic                      mem_we
);
    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    state_t  state;
    state_t  state_nx;
    logic    run;
    logic    ben;
    opcode_t opcode;

    assign opcode = opcode_t'(ir[OPC_MSB:OPC_LSB]);

    // branch enable when any requested flag is set
    assign ben = |(ir[DR_MSB:DR_LSB] & nzp);

    // run stays low for one cycle after reset so nothing fires yet
    always_ff @(posedge i_Clk)
    begin
        if (!rst_n)
        begin
            state <= S_FETCH_ADDR;
            run   <= 1'b0;
        end
        else
        begin
            state <= state_nx;
            run   <= 1'b1;
        end
    end

    always_ff @(posedge i_Clk)
    begin
        if (!rst_n)
            ir <= '0;
        else if (state == S_FETCH_IR)
            ir <= bus;
    end

    always_comb
    begin
        state_nx  = state;
        bus_src   = BUS_NONE;
        alu_op    = ALU_PASS_A;
        pc_sel    = PC_INCR;
        addr_base = BASE_PC;
        addr_off  = OFF_ZERO;
        sr1       = ir[SR1_MSB:SR1_LSB];
        sr2       = ir[SR2_MSB:SR2_LSB];
        dr        = ir[DR_MSB:DR_LSB];
        ld_reg    = 1'b0;
        ld_cc     = 1'b0;
        ld_pc     = 1'b0;
        ld_mar    = 1'b0;
        ld_mdr    = 1'b0;
        mem_start = 1'b0;
        mem_we    = 1'b0;

        if (run)
        begin
            case (state)
                S_FETCH_ADDR:
                begin
                    // MAR <- PC, PC <- PC + 1, kick off the read
                    bus_src   = BUS_PC;
                    ld_mar    = 1'b1;
                    ld_pc     = 1'b1;
                    mem_start = 1'b1;
                    state_nx  = S_FETCH_MEM;
                end
                S_FETCH_MEM:
                begin
                    if (mem_done)
                        state_nx = S_FETCH_IR;
                end
                S_FETCH_IR:
                begin
                    bus_src  = BUS_MDR;
                    state_nx = S_DECODE;
                end
                S_DECODE:
                begin
                    case (opcode)
                        OP_ADD, OP_AND, OP_NOT: state_nx = S_ALU_OP;
                        OP_LEA:                 state_nx = S_LEA;
                        OP_LD, OP_ST:           state_nx = S_MEM_ADDR;
                        OP_JMP:                 state_nx = S_JMP;
                        OP_BR:                  state_nx = ben ? S_BR_TAKE : S_FETCH_ADDR;
                        // anything else behaves as a no-op
                        default:                state_nx = S_FETCH_ADDR;
                    endcase
                end
                S_ALU_OP:
                begin
                    case (opcode)
                        OP_AND:  alu_op = ALU_AND;
                        OP_NOT:  alu_op = ALU_NOT;
                        default: alu_op = ALU_ADD;
                    endcase
                    bus_src  = BUS_ALU;
                    ld_reg   = 1'b1;
                    ld_cc    = 1'b1;
                    state_nx = S_FETCH_ADDR;
                end
                S_LEA:
                begin
                    // flags are left alone here
                    addr_off = OFF_9;
                    bus_src  = BUS_ADDR;
                    ld_reg   = 1'b1;
                    state_nx = S_FETCH_ADDR;
                end
                S_MEM_ADDR:
                begin
                    addr_off = OFF_9;
                    bus_src  = BUS_ADDR;
                    ld_mar   = 1'b1;
                    if (opcode == OP_LD)
                    begin
                        mem_start = 1'b1;
                        state_nx  = S_LD_MEM;
                    end
                    else
                        state_nx = S_ST_DATA;
                end
                S_LD_MEM:
                begin
                    if (mem_done)
                        state_nx = S_LD_REG;
                end
                S_LD_REG:
                begin
                    bus_src  = BUS_MDR;
                    ld_reg   = 1'b1;
                    ld_cc    = 1'b1;
                    state_nx = S_FETCH_ADDR;
                end
                S_ST_DATA:
                begin
                    // source register sits in the DR field for ST
                    sr1       = ir[DR_MSB:DR_LSB];
                    alu_op    = ALU_PASS_A;
                    bus_src   = BUS_ALU;
                    ld_mdr    = 1'b1;
                    mem_start = 1'b1;
                    mem_we    = 1'b1;
                    state_nx  = S_ST_MEM;
                end
                S_ST_MEM:
                begin
                    if (mem_done)
                        state_nx = S_FETCH_ADDR;
                end
                S_BR_TAKE:
                begin
                    addr_off = OFF_9;
                    pc_sel   = PC_ADDR;
                    ld_pc    = 1'b1;
                    state_nx = S_FETCH_ADDR;
                end
                S_JMP:
                begin
                    // base register routed through the adder onto the bus
                    addr_base = BASE_REG;
                    addr_off  = OFF_ZERO;
                    bus_src   = BUS_ADDR;
                    pc_sel    = PC_BUS;
                    ld_pc     = 1'b1;
                    state_nx  = S_FETCH_ADDR;
                end
                default:
                    state_nx = S_FETCH_ADDR;
            endcase
        end
    end

    a_state_legal: assert property (@(posedge i_Clk) disable iff (!rst_n)
        state inside {S_FETCH_ADDR, S_FETCH_MEM, S_FETCH_IR, S_DECODE, S_ALU_OP,
                      S_LEA, S_MEM_ADDR, S_LD_MEM, S_LD_REG, S_ST_DATA,
                      S_ST_MEM, S_BR_TAKE, S_JMP});

endmodule

// File: logic/lc3_regfile.sv
module lc3_regfile (
    input  logic                   i_Clk,
    input  logic                   rst_n,
    input  lc3_isa_pkg::word_t     bus,
    input  lc3_isa_pkg::reg_idx_t  sr1,
    input  lc3_isa_pkg::reg_idx_t  sr2,
    input  lc3_isa_pkg::reg_idx_t  dr,
    input  logic                   ld_reg,
    input  logic                   ld_cc,
    output lc3_isa_pkg::word_t     sr1_data,
    output lc3_isa_pkg::word_t     sr2_data,
    output lc3_isa_pkg::nzp_t      nzp
);
    import lc3_isa_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge i_Clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (ld_reg)
            regs[dr] <= bus;
    end

    assign sr1_data = regs[sr1];
    assign sr2_data = regs[sr2];

    // flags follow the value being written back
    always_ff @(posedge i_Clk)
    begin
        if (!rst_n)
            nzp <= NZP_RESET;
        else if (ld_cc)
            nzp <= {bus[WORD_W-1], bus == '0, !bus[WORD_W-1] && (bus != '0)};
    end

    a_cc_with_reg: assert property (@(posedge i_Clk) disable iff (!rst_n)
        ld_cc |-> ld_reg);

endmodule

// File: logic/lc3_alu.sv
module lc3_alu (
    input  lc3_isa_pkg::word_t     ir,
    input  lc3_isa_pkg::word_t     sr1_data,
    input  lc3_isa_pkg::word_t     sr2_data,
    input  lc3_ctrl_pkg::alu_op_t  alu_op,
    output lc3_isa_pkg::word_t     alu_result
);
    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    word_t imm5_sext;
    word_t operand_b;

    assign imm5_sext = {{(WORD_W - IMM5_W){ir[IMM5_W-1]}}, ir[IMM5_W-1:0]};

    // bit 5 picks the immediate form
    assign operand_b = ir[IMM_BIT] ? imm5_sext : sr2_data;

    always_comb
    begin
        case (alu_op)
            ALU_ADD:
                alu_result = sr1_data + operand_b;
            ALU_AND:
                alu_result = sr1_data & operand_b;
            ALU_NOT:
                alu_result = ~sr1_data;
            default:
                // pass A puts a store source on the bus
                alu_result = sr1_data;
        endcase
    end

endmodule

// File: logic/lc3_addr_unit.sv
module lc3_addr_unit #(
    parameter lc3_isa_pkg::word_t RESET_PC = 16'h3000
) (
    input  logic                      i_Clk,
    input  logic                      rst_n,
    input  lc3_isa_pkg::word_t        ir,
    input  lc3_isa_pkg::word_t        sr1_data,
    input  lc3_isa_pkg::word_t        bus,
    input  lc3_ctrl_pkg::addr_base_t  addr_base,
    input  lc3_ctrl_pkg::addr_off_t   addr_off,
    input  lc3_ctrl_pkg::pc_sel_t     pc_sel,
    input  logic                      ld_pc,
    output lc3_isa_pkg::word_t        pc,
    output lc3_isa_pkg::word_t        addr_result
);
    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    word_t base;
    word_t offset;

    assign base = (addr_base == BASE_REG) ? sr1_data : pc;

    always_comb
    begin
        case (addr_off)
            OFF_6:
                offset = {{(WORD_W - OFF6_W){ir[OFF6_W-1]}}, ir[OFF6_W-1:0]};
            OFF_9:
                offset = {{(WORD_W - OFF9_W){ir[OFF9_W-1]}}, ir[OFF9_W-1:0]};
            default:
                offset = '0;
        endcase
    end

    assign addr_result = base + offset;

    // PC already points past the current instruction during execute
    always_ff @(posedge i_Clk)
    begin
        if (!rst_n)
            pc <= RESET_PC;
        else if (ld_pc)
        begin
            case (pc_sel)
                PC_INCR: pc <= pc + word_t'(1);
                PC_ADDR: pc <= addr_result;
                PC_BUS:  pc <= bus;
                default: pc <= pc;
            endcase
        end
    end

endmodule

// File: logic/lc3_bus_mem.sv
module lc3_bus_mem (
    input  logic                    i_Clk,
    input  logic                    rst_n,
    input  lc3_ctrl_pkg::bus_src_t  bus_src,
    input  lc3_isa_pkg::word_t      pc,
    input  lc3_isa_pkg::word_t      addr_result,
    input  lc3_isa_pkg::word_t      alu_result,
    input  logic                    ld_mar,
    input  logic                    ld_mdr,
    input  logic                    mem_start,
    input  logic                    mem_we,
    input  lc3_isa_pkg::word_t      mem_rdata,
    input  logic                    mem_ready,
    output lc3_isa_pkg::word_t      bus,
    output logic                    mem_done,
    output logic                    mem_en,
    output lc3_isa_pkg::word_t      mem_addr,
    output lc3_isa_pkg::word_t      mem_wdata,
    output logic                    mem_we_out
);
    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    word_t mar;
    word_t mdr;

    always_comb
    begin
        case (bus_src)
            BUS_PC:   bus = pc;
            BUS_ADDR: bus = addr_result;
            BUS_ALU:  bus = alu_result;
            BUS_MDR:  bus = mdr;
            default:  bus = '0;
        endcase
    end

    // the ready cycle of an open request
    assign mem_done = mem_en && mem_ready;

    always_ff @(posedge i_Clk)
    begin
        if (ld_mar)
            mar <= bus;
    end

    always_ff @(posedge i_Clk)
    begin
        if (ld_mdr)
            mdr <= bus;
        else if (mem_done && !mem_we_out)
            mdr <= mem_rdata;
    end

    // request held from start until ready with its direction latched
    always_ff @(posedge i_Clk)
    begin
        if (!rst_n)
        begin
            mem_en     <= 1'b0;
            mem_we_out <= 1'b0;
        end
        else if (mem_start)
        begin
            mem_en     <= 1'b1;
            mem_we_out <= mem_we;
        end
        else if (mem_done)
        begin
            mem_en     <= 1'b0;
            mem_we_out <= 1'b0;
        end
    end

    assign mem_addr  = mar;
    assign mem_wdata = mdr;

    a_addr_hold: assert property (@(posedge i_Clk) disable iff (!rst_n)
        mem_en && !mem_ready |=> $stable(mem_addr));

endmodule

// File: logic/lc3_core.sv
module lc3_core #(
    parameter lc3_isa_pkg::word_t RESET_PC = 16'h3000
) (
    input  logic                i_Clk,
    input  logic                rst_n,
    output logic                mem_en,
    output logic                mem_we,
    output lc3_isa_pkg::word_t  mem_addr,
    output lc3_isa_pkg::word_t  mem_wdata,
    input  lc3_isa_pkg::word_t  mem_rdata,
    input  logic                mem_ready
);
    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    word_t      bus;
    word_t      ir;
    word_t      pc;
    word_t      addr_result;
    word_t      alu_result;
    word_t      sr1_data;
    word_t      sr2_data;
    nzp_t       nzp;
    bus_src_t   bus_src;
    alu_op_t    alu_op;
    pc_sel_t    pc_sel;
    addr_base_t addr_base;
    addr_off_t  addr_off;
    reg_idx_t   sr1;
    reg_idx_t   sr2;
    reg_idx_t   dr;
    logic       ld_reg;
    logic       ld_cc;
    logic       ld_pc;
    logic       ld_mar;
    logic       ld_mdr;
    logic       mem_start;
    logic       mem_we_req;
    logic       mem_done;

    lc3_control u_control (
        .i_Clk     (i_Clk),
        .rst_n     (rst_n),
        .bus       (bus),
        .nzp       (nzp),
        .mem_done  (mem_done),
        .ir        (ir),
        .bus_src   (bus_src),
        .alu_op    (alu_op),
        .pc_sel    (pc_sel),
        .addr_base (addr_base),
        .addr_off  (addr_off),
        .sr1       (sr1),
        .sr2       (sr2),
        .dr        (dr),
        .ld_reg    (ld_reg),
        .ld_cc     (ld_cc),
        .ld_pc     (ld_pc),
        .ld_mar    (ld_mar),
        .ld_mdr    (ld_mdr),
        .mem_start (mem_start),
        .mem_we    (mem_we_req)
    );

    lc3_regfile u_regfile (
        .i_Clk    (i_Clk),
        .rst_n    (rst_n),
        .bus      (bus),
        .sr1      (sr1),
        .sr2      (sr2),
        .dr       (dr),
        .ld_reg   (ld_reg),
        .ld_cc    (ld_cc),
        .sr1_data (sr1_data),
        .sr2_data (sr2_data),
        .nzp      (nzp)
    );

    lc3_alu u_alu (
        .ir         (ir),
        .sr1_data   (sr1_data),
        .sr2_data   (sr2_data),
        .alu_op     (alu_op),
        .alu_result (alu_result)
    );

    lc3_addr_unit #(
        .RESET_PC (RESET_PC)
    ) u_addr_unit (
        .i_Clk       (i_Clk),
        .rst_n       (rst_n),
        .ir          (ir),
        .sr1_data    (sr1_data),
        .bus         (bus),
        .addr_base   (addr_base),
        .addr_off    (addr_off),
        .pc_sel      (pc_sel),
        .ld_pc       (ld_pc),
        .pc          (pc),
        .addr_result (addr_result)
    );

    lc3_bus_mem u_bus_mem (
        .i_Clk       (i_Clk),
        .rst_n       (rst_n),
        .bus_src     (bus_src),
        .pc          (pc),
        .addr_result (addr_result),
        .alu_result  (alu_result),
        .ld_mar      (ld_mar),
        .ld_mdr      (ld_mdr),
        .mem_start   (mem_start),
        .mem_we      (mem_we_req),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .bus         (bus),
        .mem_done    (mem_done),
        .mem_en      (mem_en),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_we_out  (mem_we)
    );

endmodule

// File: sim/lc3_program.svh
`ifndef LC3_PROGRAM_SVH
`define LC3_PROGRAM_SVH

// program placement
localparam logic [15:0] PROG_BASE = 16'h3000;
localparam int          CODE_ROWS = 28;
localparam logic [15:0] HALT_ADDR = PROG_BASE + 16'd27;
localparam logic [15:0] DATA_ADDR = 16'h3040;
localparam logic [15:0] DATA_WORD = 16'h7123;

// opcodes of the kept instructions
localparam int OPC_BR  = 0;
localparam int OPC_ADD = 1;
localparam int OPC_LD  = 2;
localparam int OPC_ST  = 3;
localparam int OPC_AND = 5;
localparam int OPC_NOT = 9;
localparam int OPC_JMP = 12;
localparam int OPC_LEA = 14;

// expected stores in program order
localparam logic [3:0]  NUM_WRITES = 4'd9;
localparam logic [15:0] EXP_ADDR [NUM_WRITES] = '{
    16'h3060, 16'h3061, 16'h3062, 16'h3063, 16'h3064,
    16'h3065, 16'h3066, 16'h3067, 16'h3068
};
localparam logic [15:0] EXP_DATA [NUM_WRITES] = '{
    16'h000b, 16'h0002, 16'h0003, 16'hfff4, 16'h0007,
    16'h7123, 16'h0004, 16'h3041, 16'h000b
};

logic [15:0] prog_code [CODE_ROWS];

function automatic int row_addr(input int row);
    return int'(PROG_BASE) + row;
endfunction

function automatic logic [15:0] alu_reg_word(input int op, input int d, input int s1,
                                             input int s2);
    return {op[3:0], d[2:0], s1[2:0], 3'b000, s2[2:0]};
endfunction

function automatic logic [15:0] alu_imm_word(input int op, input int d, input int s,
                                             input int imm);
    return {op[3:0], d[2:0], s[2:0], 1'b1, imm[4:0]};
endfunction

function automatic logic [15:0] not_word(input int d, input int s);
    return {OPC_NOT[3:0], d[2:0], s[2:0], 6'b111111};
endfunction

// offset counts from the word after the instruction
function automatic logic [15:0] pcrel_word(input int op, input int r, input int row,
                                           input int target);
    int off;
    off = target - (row_addr(row) + 1);
    return {op[3:0], r[2:0], off[8:0]};
endfunction

function automatic logic [15:0] jmp_word(input int base);
    return {OPC_JMP[3:0], 3'b000, base[2:0], 6'b000000};
endfunction

task automatic build_program;
    // ALU forms with each result stored
    prog_code[0]  = alu_imm_word(OPC_ADD, 1, 0, 7);
    prog_code[1]  = alu_imm_word(OPC_ADD, 2, 1, -3);
    prog_code[2]  = alu_reg_word(OPC_ADD, 3, 1, 2);
    prog_code[3]  = pcrel_word(OPC_ST, 3, 3, 'h3060);
    prog_code[4]  = alu_imm_word(OPC_AND, 4, 3, 6);
    prog_code[5]  = pcrel_word(OPC_ST, 4, 5, 'h3061);
    prog_code[6]  = alu_reg_word(OPC_AND, 5, 3, 1);
    prog_code[7]  = pcrel_word(OPC_ST, 5, 7, 'h3062);
    prog_code[8]  = not_word(6, 3);
    prog_code[9]  = pcrel_word(OPC_ST, 6, 9, 'h3063);
    // BRzp after a negative result falls through to the marker
    prog_code[10] = pcrel_word(OPC_BR, 3, 10, row_addr(12));
    prog_code[11] = pcrel_word(OPC_ST, 1, 11, 'h3064);
    // LD then ST copies the data word
    prog_code[12] = pcrel_word(OPC_LD, 7, 12, int'(DATA_ADDR));
    prog_code[13] = pcrel_word(OPC_ST, 7, 13, 'h3065);
    // flags are still n before the LD so only a positive load takes BRp
    prog_code[14] = pcrel_word(OPC_BR, 1, 14, row_addr(16));
    prog_code[15] = pcrel_word(OPC_ST, 1, 15, 'h3066);
    prog_code[16] = pcrel_word(OPC_ST, 2, 16, 'h3066);
    // zero flag must survive the LEA
    prog_code[17] = alu_imm_word(OPC_AND, 5, 5, 0);
    prog_code[18] = pcrel_word(OPC_LEA, 4, 18, 'h3041);
    prog_code[19] = pcrel_word(OPC_BR, 2, 19, row_addr(21));
    prog_code[20] = pcrel_word(OPC_ST, 1, 20, 'h3067);
    prog_code[21] = pcrel_word(OPC_ST, 4, 21, 'h3067);
    // jump over the wrong marker through R6
    prog_code[22] = pcrel_word(OPC_LEA, 6, 22, row_addr(26));
    prog_code[23] = jmp_word(6);
    prog_code[24] = pcrel_word(OPC_ST, 1, 24, 'h3068);
    prog_code[25] = pcrel_word(OPC_BR, 7, 25, row_addr(27));
    prog_code[26] = pcrel_word(OPC_ST, 3, 26, 'h3068);
    // final loop branching to itself
    prog_code[27] = pcrel_word(OPC_BR, 7, 27, row_addr(27));
endtask

`endif

// File: sim/tb_lc3_core.sv
module tb_lc3_core;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 4;
    localparam int MAX_DELAY       = 3;

    `include "lc3_program.svh"

    localparam int WATCHDOG_CYCLES = CODE_ROWS * 40 * MAX_DELAY;

    logic        i_Clk     = 1'b0;
    logic        rst_n     = 1'b0;
    logic        mem_ready = 1'b0;
    logic [15:0] mem_rdata = 16'h0000;
    logic        mem_en;
    logic        mem_we;
    logic [15:0] mem_addr;
    logic [15:0] mem_wdata;

    logic [15:0] mem [0:65535];
    logic        mem_loaded      = 1'b0;
    logic        busy            = 1'b0;
    logic        first_read_seen = 1'b0;
    logic        halt_seen       = 1'b0;
    logic [1:0]  wait_left       = 2'd0;
    logic [15:0] req_addr        = 16'h0000;
    logic [31:0] rng_state       = 32'h47d56196;
    logic [3:0]  writes_seen     = 4'd0;
    int          errors          = 0;
    int          neg_count       = 0;
    int          after_reset     = 0;

    lc3_core #(
        .RESET_PC (PROG_BASE)
    ) DUT (
        .i_Clk     (i_Clk),
        .rst_n     (rst_n),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    always #(CLK_PERIOD / 2) i_Clk = ~i_Clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // unused locations hold a pattern built from the full address
    function automatic logic [15:0] fill_word(input int a);
        return {a[7:0], a[15:8]} ^ 16'h5a3c;
    endfunction

    task automatic load_memory;
        build_program();
        for (int a = 0; a < 65536; a++)
            mem[16'(a)] = fill_word(a);
        for (int i = 0; i < CODE_ROWS; i++)
            mem[PROG_BASE + 16'(i)] = prog_code[5'(i)];
        mem[DATA_ADDR] = DATA_WORD;
    endtask

    task automatic check_idle;
        if (mem_en !== 1'b0)
        begin
            errors++;
            $display("FAIL mem_en expected 0 got %h around reset", mem_en);
        end
        if (mem_we !== 1'b0)
        begin
            errors++;
            $display("FAIL mem_we expected 0 got %h around reset", mem_we);
        end
    endtask

    task automatic check_write;
        if (writes_seen >= NUM_WRITES)
        begin
            errors++;
            $display("unexpected write of %h to address %h after the last expected store",
                     mem_wdata, mem_addr);
        end
        else
        begin
            if (mem_addr !== EXP_ADDR[writes_seen])
            begin
                errors++;
                $display("FAIL mem_addr expected %h got %h (write %0d)",
                         EXP_ADDR[writes_seen], mem_addr, writes_seen);
            end
            if (mem_wdata !== EXP_DATA[writes_seen])
            begin
                errors++;
                $display("FAIL mem_wdata expected %h got %h (write %0d)",
                         EXP_DATA[writes_seen], mem_wdata, writes_seen);
            end
            writes_seen = writes_seen + 4'd1;
        end
    endtask

    task automatic open_request;
        busy      = 1'b1;
        req_addr  = mem_addr;
        rng_state = lcg_next(rng_state);
        wait_left = rng_state[17:16];
        if (!first_read_seen)
        begin
            first_read_seen = 1'b1;
            if (mem_we !== 1'b0)
            begin
                errors++;
                $display("first request after reset is a write, not an instruction fetch");
            end
            if (mem_addr !== PROG_BASE)
            begin
                errors++;
                $display("FAIL mem_addr expected %h got %h (first fetch)", PROG_BASE, mem_addr);
            end
        end
        if (!mem_we && mem_addr == HALT_ADDR)
            halt_seen = 1'b1;
    endtask

    task automatic complete_request;
        mem_ready = 1'b1;
        if (mem_we)
        begin
            mem[mem_addr] = mem_wdata;
            check_write();
        end
        else
            mem_rdata = mem[mem_addr];
    endtask

    task automatic serve_memory;
        if (mem_ready)
        begin
            // handshake closed at the last rising edge
            mem_ready = 1'b0;
            busy      = 1'b0;
            if (mem_en !== 1'b0)
            begin
                errors++;
                $display("FAIL mem_en expected 0 got %h in the cycle after ready", mem_en);
            end
        end
        else if (mem_en)
        begin
            if (!busy)
                open_request();
            else if (mem_addr !== req_addr)
            begin
                errors++;
                $display("address moved from %h to %h while waiting for ready",
                         req_addr, mem_addr);
            end
            if (wait_left == 2'd0)
                complete_request();
            else
                wait_left = wait_left - 2'd1;
        end
    endtask

    task automatic print_summary;
        $display("writes checked %0d of %0d, errors %0d", writes_seen, NUM_WRITES, errors);
    endtask

    // reset, memory model and checks all live on the falling edge
    always @(negedge i_Clk)
    begin
        if (!mem_loaded)
        begin
            load_memory();
            mem_loaded = 1'b1;
        end
        if (!rst_n)
        begin
            check_idle();
            neg_count++;
            if (neg_count == RESET_CYCLES)
                rst_n = 1'b1;
        end
        else
        begin
            after_reset++;
            if (after_reset == 1)
                check_idle();
            serve_memory();
        end
    end

    initial
    begin
        wait (halt_seen);
        if (writes_seen != NUM_WRITES)
            $display("final loop reached after %0d of %0d expected writes",
                     writes_seen, NUM_WRITES);
        print_summary();
        if (errors == 0 && writes_seen == NUM_WRITES)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, final loop never reached", WATCHDOG_CYCLES);
        print_summary();
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+sim
logic/lc3_isa_pkg.sv
logic/lc3_ctrl_pkg.sv
logic/lc3_control.sv
logic/lc3_regfile.sv
logic/lc3_alu.sv
logic/lc3_addr_unit.sv
logic/lc3_bus_mem.sv
logic/lc3_core.sv
sim/tb_lc3_core.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall
TOP        := tb_lc3_core
RTL_TOP    := lc3_core
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
